//--- common/f8_defs.svh
`ifndef F8_DEFS_SVH
`define F8_DEFS_SVH

// datapath widths
`define F8_WORD_W 16
`define F8_BYTE_W 8
`define F8_INST_W 24

// first fetch address out of reset
`define F8_RESET_PC 16'h4000

// pc increments by instruction length
`define F8_LEN_1 16'd1
`define F8_LEN_2 16'd2
`define F8_LEN_3 16'd3

// register file indices
`define F8_REG_X 2'd0
`define F8_REG_Y 2'd1
`define F8_REG_Z 2'd2

`endif

//--- common/f8_isa_pkg.sv
`include "f8_defs.svh"

package f8_isa_pkg;

	typedef enum logic [`F8_BYTE_W-1:0] {
		// one byte
		NOP         = 8'h00,
		TRAP        = 8'h01,
		INC_XL      = 8'h02,
		DEC_XL      = 8'h03,
		ADD_XL_YL   = 8'h04,
		SUB_XL_ZL   = 8'h05,
		AND_XL_YL   = 8'h06,
		XOR_XL_ZL   = 8'h07,
		// two bytes, imm8 or displacement
		LD_XL_IMMD  = 8'h40,
		ADD_XL_IMMD = 8'h41,
		ADC_XL_IMMD = 8'h42,
		SUB_XL_IMMD = 8'h43,
		AND_XL_IMMD = 8'h44,
		OR_XL_IMMD  = 8'h45,
		XOR_XL_IMMD = 8'h46,
		JR_D        = 8'h48,
		JRZ_D       = 8'h49,
		JRNZ_D      = 8'h4a,
		JRC_D       = 8'h4b,
		// three bytes, imm16 or direct address
		LDW_Y_IMMD  = 8'h80,
		LDW_Z_IMMD  = 8'h81,
		LD_XL_DIR   = 8'h82,
		LD_DIR_XL   = 8'h83,
		LDW_DIR_Y   = 8'h84,
		JP_IMMD     = 8'h85
	} opcode_t;

	// opcode sits in the first byte fetched
	typedef union packed {
		struct packed {
			logic [`F8_WORD_W-1:0] imm16;
			opcode_t               opcode;
		} wide;
		struct packed {
			logic [`F8_BYTE_W-1:0] pad;
			logic [`F8_BYTE_W-1:0] imm8;
			opcode_t               opcode;
		} narrow;
	} inst_t;

	typedef enum logic [3:0] {
		PASS_B,
		ADD,
		ADC,
		SUB,
		AND,
		OR,
		XOR,
		INC,
		DEC
	} alu_op_t;

	typedef struct packed {
		logic o;
		logic z;
		logic n;
		logic c;
	} flags_t;

endpackage

//--- common/f8_bus_pkg.sv
`include "f8_defs.svh"

package f8_bus_pkg;

	// direct read, answered one cycle later
	typedef struct packed {
		logic [`F8_WORD_W-1:0] addr;
		logic                  en;
	} dread_t;

	// en[0] low byte, en[1] high byte
	typedef struct packed {
		logic [`F8_WORD_W-1:0] addr;
		logic [`F8_WORD_W-1:0] data;
		logic [1:0]            en;
	} dwrite_t;

endpackage

//--- core/f8_decoder.sv
`timescale 1ns/1ns

`include "f8_defs.svh"

module f8_decoder (
	input  f8_isa_pkg::inst_t        exec_inst,
	input  logic [`F8_WORD_W-1:0]    x,
	input  logic [`F8_WORD_W-1:0]    y,
	input  logic [`F8_WORD_W-1:0]    z,
	input  logic [`F8_BYTE_W-1:0]    result,
	input  logic [`F8_WORD_W-1:0]    dread_data,
	output f8_isa_pkg::alu_op_t      alu_op,
	output logic [`F8_BYTE_W-1:0]    alu_a,
	output logic [`F8_BYTE_W-1:0]    alu_b,
	output logic                     flag_en,
	output logic [1:0]               reg_addr,
	output logic [1:0]               reg_en,
	output logic [`F8_WORD_W-1:0]    reg_data,
	output f8_bus_pkg::dwrite_t      dwrite,
	output logic                     trap
);

	f8_isa_pkg::opcode_t op;

	assign op = exec_inst.wide.opcode;

	always_comb
	begin
		// accumulator ops on xl with imm8 unless noted
		alu_op = f8_isa_pkg::PASS_B;
		alu_a = x[`F8_BYTE_W-1:0];
		alu_b = exec_inst.narrow.imm8;
		flag_en = 1'b0;
		reg_addr = `F8_REG_X;
		reg_en = 2'b00;
		reg_data = {{`F8_BYTE_W{1'b0}}, result};
		dwrite.addr = exec_inst.wide.imm16;
		dwrite.data = {{`F8_BYTE_W{1'b0}}, x[`F8_BYTE_W-1:0]};
		dwrite.en = 2'b00;
		trap = 1'b0;

		case (op)
			f8_isa_pkg::TRAP:
				trap = 1'b1;
			f8_isa_pkg::INC_XL:
			begin
				alu_op = f8_isa_pkg::INC;
				flag_en = 1'b1;
				reg_en = 2'b01;
			end
			f8_isa_pkg::DEC_XL:
			begin
				alu_op = f8_isa_pkg::DEC;
				flag_en = 1'b1;
				reg_en = 2'b01;
			end
			f8_isa_pkg::ADD_XL_YL, f8_isa_pkg::AND_XL_YL:
			begin
				alu_op = (op == f8_isa_pkg::ADD_XL_YL) ? f8_isa_pkg::ADD : f8_isa_pkg::AND;
				alu_b = y[`F8_BYTE_W-1:0];
				flag_en = 1'b1;
				reg_en = 2'b01;
			end
			f8_isa_pkg::SUB_XL_ZL, f8_isa_pkg::XOR_XL_ZL:
			begin
				alu_op = (op == f8_isa_pkg::SUB_XL_ZL) ? f8_isa_pkg::SUB : f8_isa_pkg::XOR;
				alu_b = z[`F8_BYTE_W-1:0];
				flag_en = 1'b1;
				reg_en = 2'b01;
			end
			// plain loads leave the flags alone
			f8_isa_pkg::LD_XL_IMMD:
				reg_en = 2'b01;
			f8_isa_pkg::ADD_XL_IMMD, f8_isa_pkg::ADC_XL_IMMD, f8_isa_pkg::SUB_XL_IMMD,
			f8_isa_pkg::AND_XL_IMMD, f8_isa_pkg::OR_XL_IMMD, f8_isa_pkg::XOR_XL_IMMD:
			begin
				case (op)
					f8_isa_pkg::ADD_XL_IMMD: alu_op = f8_isa_pkg::ADD;
					f8_isa_pkg::ADC_XL_IMMD: alu_op = f8_isa_pkg::ADC;
					f8_isa_pkg::SUB_XL_IMMD: alu_op = f8_isa_pkg::SUB;
					f8_isa_pkg::AND_XL_IMMD: alu_op = f8_isa_pkg::AND;
					f8_isa_pkg::OR_XL_IMMD:  alu_op = f8_isa_pkg::OR;
					default:                 alu_op = f8_isa_pkg::XOR;
				endcase
				flag_en = 1'b1;
				reg_en = 2'b01;
			end
			// read was issued when this instruction arrived
			f8_isa_pkg::LD_XL_DIR:
			begin
				reg_en = 2'b01;
				reg_data = dread_data;
			end
			f8_isa_pkg::LDW_Y_IMMD, f8_isa_pkg::LDW_Z_IMMD:
			begin
				reg_addr = (op == f8_isa_pkg::LDW_Y_IMMD) ? `F8_REG_Y : `F8_REG_Z;
				reg_en = 2'b11;
				reg_data = exec_inst.wide.imm16;
			end
			f8_isa_pkg::LD_DIR_XL:
				dwrite.en = 2'b01;
			f8_isa_pkg::LDW_DIR_Y:
			begin
				dwrite.data = y;
				dwrite.en = 2'b11;
			end
			// branches and unknown opcodes act as nop here
			default: ;
		endcase
	end

endmodule

//--- core/f8_alu.sv
`timescale 1ns/1ns

`include "f8_defs.svh"

module f8_alu (
	input  logic                     clk,
	input  logic                     reset,
	input  f8_isa_pkg::alu_op_t      alu_op,
	input  logic [`F8_BYTE_W-1:0]    alu_a,
	input  logic [`F8_BYTE_W-1:0]    alu_b,
	input  logic                     flag_en,
	output logic [`F8_BYTE_W-1:0]    result,
	output f8_isa_pkg::flags_t       next_flags
);

	f8_isa_pkg::flags_t flags;
	f8_isa_pkg::flags_t alu_flags;
	logic [`F8_BYTE_W-1:0] b_eff;
	logic [`F8_BYTE_W-1:0] b_add;
	logic [`F8_BYTE_W:0] sum;
	logic subtract;
	logic carry_in;
	logic ovf;

	// one adder for add, adc, sub, inc and dec
	always_comb
	begin
		b_eff = alu_b;
		subtract = 1'b0;
		carry_in = 1'b0;
		case (alu_op)
			f8_isa_pkg::ADC: carry_in = flags.c;
			f8_isa_pkg::SUB: subtract = 1'b1;
			f8_isa_pkg::INC: b_eff = `F8_BYTE_W'(1);
			f8_isa_pkg::DEC:
			begin
				b_eff = `F8_BYTE_W'(1);
				subtract = 1'b1;
			end
			default: ;
		endcase
	end

	// a - b as a + ~b + 1, so carry out is the inverted borrow
	assign b_add = subtract ? ~b_eff : b_eff;
	assign sum = alu_a + b_add + (subtract | carry_in);
	assign ovf = (alu_a[`F8_BYTE_W-1] == b_add[`F8_BYTE_W-1]) &&
		(sum[`F8_BYTE_W-1] != alu_a[`F8_BYTE_W-1]);

	always_comb
	begin
		case (alu_op)
			f8_isa_pkg::AND: result = alu_a & alu_b;
			f8_isa_pkg::OR:  result = alu_a | alu_b;
			f8_isa_pkg::XOR: result = alu_a ^ alu_b;
			f8_isa_pkg::PASS_B: result = alu_b;
			default: result = sum[`F8_BYTE_W-1:0];
		endcase

		alu_flags.z = (result == '0);
		alu_flags.n = result[`F8_BYTE_W-1];
		alu_flags.o = ovf;
		alu_flags.c = subtract ? ~sum[`F8_BYTE_W] : sum[`F8_BYTE_W];
		case (alu_op)
			f8_isa_pkg::AND, f8_isa_pkg::OR, f8_isa_pkg::XOR, f8_isa_pkg::PASS_B:
			begin
				alu_flags.o = 1'b0;
				alu_flags.c = 1'b0;
			end
			// inc and dec keep the carry
			f8_isa_pkg::INC, f8_isa_pkg::DEC:
				alu_flags.c = flags.c;
			default: ;
		endcase
	end

	assign next_flags = flag_en ? alu_flags : flags;

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

endmodule

//--- core/f8_regfile.sv
`timescale 1ns/1ns

`include "f8_defs.svh"

module f8_regfile (
	input  logic                     clk,
	input  logic [1:0]               reg_addr,
	input  logic [1:0]               reg_en,
	input  logic [`F8_WORD_W-1:0]    reg_data,
	output logic [`F8_WORD_W-1:0]    x,
	output logic [`F8_WORD_W-1:0]    y,
	output logic [`F8_WORD_W-1:0]    z,
	output logic [`F8_WORD_W-1:0]    next_x,
	output logic [`F8_WORD_W-1:0]    next_y,
	output logic [`F8_WORD_W-1:0]    next_z
);

	logic [`F8_WORD_W-1:0] regs [3];
	logic [`F8_WORD_W-1:0] next_regs [3];

	// per-byte merge of the write into each register
	for (genvar i = 0; i < 3; i++)
	begin : g_reg
		logic hit;

		assign hit = (reg_addr == 2'(i));
		assign next_regs[i][`F8_WORD_W-1:`F8_BYTE_W] = (hit && reg_en[1]) ?
			reg_data[`F8_WORD_W-1:`F8_BYTE_W] : regs[i][`F8_WORD_W-1:`F8_BYTE_W];
		assign next_regs[i][`F8_BYTE_W-1:0] = (hit && reg_en[0]) ?
			reg_data[`F8_BYTE_W-1:0] : regs[i][`F8_BYTE_W-1:0];
	end

	always_ff @(posedge clk)
	begin
		regs <= next_regs;
	end

	assign x = regs[`F8_REG_X];
	assign y = regs[`F8_REG_Y];
	assign z = regs[`F8_REG_Z];

	assign next_x = next_regs[`F8_REG_X];
	assign next_y = next_regs[`F8_REG_Y];
	assign next_z = next_regs[`F8_REG_Z];

endmodule

//--- core/f8_fetch.sv
`timescale 1ns/1ns

`include "f8_defs.svh"

module f8_fetch (
	input  logic                     clk,
	input  logic                     reset,
	input  f8_isa_pkg::inst_t        iread_data,
	input  logic                     iread_valid,
	input  f8_isa_pkg::flags_t       next_flags,
	output logic [`F8_WORD_W-1:0]    iread_addr,
	output f8_bus_pkg::dread_t       dread,
	output f8_isa_pkg::inst_t        exec_inst
);

	// pc is the address of the word arriving this cycle
	logic [`F8_WORD_W-1:0] pc;
	logic [`F8_WORD_W-1:0] next_pc;
	logic [`F8_WORD_W-1:0] disp;
	logic fetch_on;
	logic arrived;
	logic taken;
	f8_isa_pkg::opcode_t op;

	function automatic logic [`F8_WORD_W-1:0] inst_len(input f8_isa_pkg::opcode_t opc);
		case (opc)
			f8_isa_pkg::LD_XL_IMMD, f8_isa_pkg::ADD_XL_IMMD, f8_isa_pkg::ADC_XL_IMMD,
			f8_isa_pkg::SUB_XL_IMMD, f8_isa_pkg::AND_XL_IMMD, f8_isa_pkg::OR_XL_IMMD,
			f8_isa_pkg::XOR_XL_IMMD, f8_isa_pkg::JR_D, f8_isa_pkg::JRZ_D,
			f8_isa_pkg::JRNZ_D, f8_isa_pkg::JRC_D:
				inst_len = `F8_LEN_2;
			f8_isa_pkg::LDW_Y_IMMD, f8_isa_pkg::LDW_Z_IMMD, f8_isa_pkg::LD_XL_DIR,
			f8_isa_pkg::LD_DIR_XL, f8_isa_pkg::LDW_DIR_Y, f8_isa_pkg::JP_IMMD:
				inst_len = `F8_LEN_3;
			default:
				inst_len = `F8_LEN_1;
		endcase
	endfunction

	// nothing has been requested yet in the first cycle out of reset
	assign arrived = iread_valid && fetch_on;
	assign op = iread_data.wide.opcode;
	assign disp = {{`F8_BYTE_W{iread_data.narrow.imm8[`F8_BYTE_W-1]}}, iread_data.narrow.imm8};

	// conditions see the flags of the instruction executing now
	always_comb
	begin
		case (op)
			f8_isa_pkg::JR_D:   taken = 1'b1;
			f8_isa_pkg::JRZ_D:  taken = next_flags.z;
			f8_isa_pkg::JRNZ_D: taken = !next_flags.z;
			f8_isa_pkg::JRC_D:  taken = next_flags.c;
			default:            taken = 1'b0;
		endcase

		if (!arrived)
			next_pc = pc;
		else if (op == f8_isa_pkg::JP_IMMD)
			next_pc = iread_data.wide.imm16;
		else if (taken)
			next_pc = pc + `F8_LEN_2 + disp;
		else
			next_pc = pc + inst_len(op);
	end

	assign iread_addr = next_pc;

	always_comb
	begin
		dread.addr = iread_data.wide.imm16;
		dread.en = arrived && (op == f8_isa_pkg::LD_XL_DIR);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= `F8_RESET_PC;
			fetch_on <= 1'b0;
			exec_inst <= f8_isa_pkg::inst_t'(`F8_INST_W'(f8_isa_pkg::NOP));
		end
		else
		begin
			pc <= next_pc;
			fetch_on <= 1'b1;
			// bubble on a stalled fetch
			exec_inst <= arrived ? iread_data :
				f8_isa_pkg::inst_t'(`F8_INST_W'(f8_isa_pkg::NOP));
		end
	end

endmodule

//--- rtl/f8_core.sv
`timescale 1ns/1ns

`include "f8_defs.svh"

module f8_core (
	input  logic                     clk,
	input  logic                     reset,
	output logic [`F8_WORD_W-1:0]    iread_addr,
	input  f8_isa_pkg::inst_t        iread_data,
	input  logic                     iread_valid,
	output f8_bus_pkg::dread_t       dread,
	input  logic [`F8_WORD_W-1:0]    dread_data,
	output f8_bus_pkg::dwrite_t      dwrite,
	output logic                     trap
);

	f8_isa_pkg::inst_t exec_inst;
	f8_isa_pkg::alu_op_t alu_op;
	f8_isa_pkg::flags_t next_flags;
	logic [`F8_BYTE_W-1:0] alu_a;
	logic [`F8_BYTE_W-1:0] alu_b;
	logic [`F8_BYTE_W-1:0] result;
	logic flag_en;
	logic [1:0] reg_addr;
	logic [1:0] reg_en;
	logic [`F8_WORD_W-1:0] reg_data;
	logic [`F8_WORD_W-1:0] x;
	logic [`F8_WORD_W-1:0] y;
	logic [`F8_WORD_W-1:0] z;

	f8_fetch u_fetch (.clk, .reset, .iread_data, .iread_valid, .next_flags,
		.iread_addr, .dread, .exec_inst);

	f8_decoder u_decoder (.exec_inst, .x, .y, .z, .result, .dread_data, .alu_op, .alu_a,
		.alu_b, .flag_en, .reg_addr, .reg_en, .reg_data, .dwrite, .trap);

	f8_alu u_alu (.clk, .reset, .alu_op, .alu_a, .alu_b, .flag_en, .result, .next_flags);

	// bypassed values are not needed at this level
	f8_regfile u_regfile (.clk, .reg_addr, .reg_en, .reg_data, .x, .y, .z,
		.next_x(), .next_y(), .next_z());

endmodule

//--- verification/f8_ref_model.svh
`ifndef F8_REF_MODEL_SVH
`define F8_REF_MODEL_SVH

// 8-bit accumulator step, flags updated in place
function automatic logic [7:0] arith(input f8_isa_pkg::alu_op_t k, input logic [7:0] a,
	input logic [7:0] b, inout f8_isa_pkg::flags_t f);
	logic [8:0] s;
	logic [7:0] r;

	r = b;
	case (k)
		f8_isa_pkg::ADD, f8_isa_pkg::ADC:
		begin
			s = a + b + ((k == f8_isa_pkg::ADC) ? f.c : 1'b0);
			r = s[7:0];
			f.c = s[8];
			f.o = (a[7] == b[7]) && (r[7] != a[7]);
		end
		f8_isa_pkg::SUB:
		begin
			s = {1'b0, a} - {1'b0, b};
			r = s[7:0];
			// borrow
			f.c = s[8];
			f.o = (a[7] != b[7]) && (r[7] != a[7]);
		end
		f8_isa_pkg::AND, f8_isa_pkg::OR, f8_isa_pkg::XOR:
		begin
			if (k == f8_isa_pkg::AND)
				r = a & b;
			else if (k == f8_isa_pkg::OR)
				r = a | b;
			else
				r = a ^ b;
			f.c = 1'b0;
			f.o = 1'b0;
		end
		f8_isa_pkg::INC:
		begin
			r = a + 8'd1;
			f.o = (a == 8'h7f);
		end
		f8_isa_pkg::DEC:
		begin
			r = a - 8'd1;
			f.o = (a == 8'h80);
		end
		default: ;
	endcase
	f.z = (r == 8'h00);
	f.n = r[7];
	return r;
endfunction

// runs the program at the reset pc over a copy of the initial data memory
task automatic run_model(output bit trap_hit);
	logic [15:0] pc;
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] z;
	logic [15:0] imm16;
	logic [15:0] disp;
	logic [7:0] op;
	logic [7:0] imm8;
	f8_isa_pkg::flags_t f;
	f8_bus_pkg::dwrite_t w;
	bit taken;
	bit done;
	int steps;

	model_mem = dmem_init;
	exp_q.delete();
	pc = `F8_RESET_PC;
	x = '0;
	y = '0;
	z = '0;
	f = '0;
	trap_hit = 1'b0;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 1000)
	begin
		op = imem[pc];
		imm8 = imem[pc + 16'd1];
		imm16 = {imem[pc + 16'd2], imem[pc + 16'd1]};
		disp = {{8{imm8[7]}}, imm8};
		taken = 1'b0;
		case (op)
			f8_isa_pkg::TRAP:
			begin
				trap_hit = 1'b1;
				done = 1'b1;
			end
			f8_isa_pkg::INC_XL:      x[7:0] = arith(f8_isa_pkg::INC, x[7:0], 8'h00, f);
			f8_isa_pkg::DEC_XL:      x[7:0] = arith(f8_isa_pkg::DEC, x[7:0], 8'h00, f);
			f8_isa_pkg::ADD_XL_YL:   x[7:0] = arith(f8_isa_pkg::ADD, x[7:0], y[7:0], f);
			f8_isa_pkg::SUB_XL_ZL:   x[7:0] = arith(f8_isa_pkg::SUB, x[7:0], z[7:0], f);
			f8_isa_pkg::AND_XL_YL:   x[7:0] = arith(f8_isa_pkg::AND, x[7:0], y[7:0], f);
			f8_isa_pkg::XOR_XL_ZL:   x[7:0] = arith(f8_isa_pkg::XOR, x[7:0], z[7:0], f);
			f8_isa_pkg::LD_XL_IMMD:  x[7:0] = imm8;
			f8_isa_pkg::ADD_XL_IMMD: x[7:0] = arith(f8_isa_pkg::ADD, x[7:0], imm8, f);
			f8_isa_pkg::ADC_XL_IMMD: x[7:0] = arith(f8_isa_pkg::ADC, x[7:0], imm8, f);
			f8_isa_pkg::SUB_XL_IMMD: x[7:0] = arith(f8_isa_pkg::SUB, x[7:0], imm8, f);
			f8_isa_pkg::AND_XL_IMMD: x[7:0] = arith(f8_isa_pkg::AND, x[7:0], imm8, f);
			f8_isa_pkg::OR_XL_IMMD:  x[7:0] = arith(f8_isa_pkg::OR, x[7:0], imm8, f);
			f8_isa_pkg::XOR_XL_IMMD: x[7:0] = arith(f8_isa_pkg::XOR, x[7:0], imm8, f);
			f8_isa_pkg::JR_D:        taken = 1'b1;
			f8_isa_pkg::JRZ_D:       taken = f.z;
			f8_isa_pkg::JRNZ_D:      taken = !f.z;
			f8_isa_pkg::JRC_D:       taken = f.c;
			f8_isa_pkg::LDW_Y_IMMD:  y = imm16;
			f8_isa_pkg::LDW_Z_IMMD:  z = imm16;
			f8_isa_pkg::LD_XL_DIR:   x[7:0] = model_mem[imm16];
			f8_isa_pkg::LD_DIR_XL:
			begin
				w.addr = imm16;
				w.data = {8'h00, x[7:0]};
				w.en = 2'b01;
				exp_q.push_back(w);
				model_mem[imm16] = x[7:0];
			end
			f8_isa_pkg::LDW_DIR_Y:
			begin
				w.addr = imm16;
				w.data = y;
				w.en = 2'b11;
				exp_q.push_back(w);
				model_mem[imm16] = y[7:0];
				model_mem[imm16 + 16'd1] = y[15:8];
			end
			default: ;
		endcase

		case (op)
			f8_isa_pkg::JP_IMMD:
				pc = imm16;
			f8_isa_pkg::LDW_Y_IMMD, f8_isa_pkg::LDW_Z_IMMD, f8_isa_pkg::LD_XL_DIR,
			f8_isa_pkg::LD_DIR_XL, f8_isa_pkg::LDW_DIR_Y:
				pc = pc + 16'd3;
			f8_isa_pkg::LD_XL_IMMD, f8_isa_pkg::ADD_XL_IMMD, f8_isa_pkg::ADC_XL_IMMD,
			f8_isa_pkg::SUB_XL_IMMD, f8_isa_pkg::AND_XL_IMMD, f8_isa_pkg::OR_XL_IMMD,
			f8_isa_pkg::XOR_XL_IMMD, f8_isa_pkg::JR_D, f8_isa_pkg::JRZ_D,
			f8_isa_pkg::JRNZ_D, f8_isa_pkg::JRC_D:
				pc = taken ? pc + 16'd2 + disp : pc + 16'd2;
			default:
				pc = pc + 16'd1;
		endcase
		steps++;
	end
endtask

`endif

//--- verification/f8_tb.sv
`timescale 1ns/1ns

`include "f8_defs.svh"

module f8_tb;

	logic clk;
	logic reset;
	logic [`F8_WORD_W-1:0] iread_addr;
	f8_isa_pkg::inst_t iread_data;
	logic iread_valid;
	f8_bus_pkg::dread_t dread;
	logic [`F8_WORD_W-1:0] dread_data;
	f8_bus_pkg::dwrite_t dwrite;
	logic trap;

	logic [7:0] imem [65536];
	logic [7:0] dmem [65536];
	logic [7:0] dmem_init [65536];
	logic [7:0] model_mem [65536];
	f8_bus_pkg::dwrite_t exp_q[$];
	f8_bus_pkg::dwrite_t obs_q[$];
	f8_bus_pkg::dread_t s_dread;
	f8_bus_pkg::dwrite_t s_dwrite;
	logic [`F8_WORD_W-1:0] s_iaddr;
	logic [15:0] gp;
	bit stall_mode;
	bit exp_trap;
	bit trap_seen;
	int late_writes;
	int seed = 16750;
	int errors;
	int tests_passed;
	int tests_failed;

	`include "f8_ref_model.svh"

	f8_core u_dut (.clk, .reset, .iread_addr, .iread_data, .iread_valid, .dread,
		.dread_data, .dwrite, .trap);

	always #2 clk = ~clk;

	// outputs are sampled mid-cycle, away from the edge
	always @(negedge clk)
	begin
		s_iaddr = iread_addr;
		s_dread = dread;
		s_dwrite = dwrite;
		if (!reset)
		begin
			if (dwrite.en != 2'b00)
			begin
				if (trap_seen)
					late_writes++;
				else
					obs_q.push_back(dwrite);
			end
			if (trap)
				trap_seen = 1'b1;
		end
	end

	// synchronous memories, write before read
	always @(posedge clk)
	begin
		if (s_dwrite.en[0])
			dmem[s_dwrite.addr] = s_dwrite.data[7:0];
		if (s_dwrite.en[1])
			dmem[s_dwrite.addr + 16'd1] = s_dwrite.data[15:8];
		iread_data <= {imem[s_iaddr + 16'd2], imem[s_iaddr + 16'd1], imem[s_iaddr]};
		iread_valid <= stall_mode ? (($random(seed) % 4) != 0) : 1'b1;
		if (s_dread.en)
			dread_data <= {dmem[s_dread.addr + 16'd1], dmem[s_dread.addr]};
	end

	task automatic check_write(input f8_bus_pkg::dwrite_t got, input f8_bus_pkg::dwrite_t exp,
		input int idx);
		bit bad;

		bad = (got.addr !== exp.addr) || (got.en !== exp.en);
		if (exp.en[0] && got.data[7:0] !== exp.data[7:0])
			bad = 1'b1;
		if (exp.en[1] && got.data[15:8] !== exp.data[15:8])
			bad = 1'b1;
		if (bad)
		begin
			$display("[FAIL] %0t ns dwrite[%0d] got addr=%h data=%h en=%b exp addr=%h data=%h en=%b",
				$time, idx, got.addr, got.data, got.en, exp.addr, exp.data, exp.en);
			errors++;
		end
	endtask

	task automatic check_trap(input bit got, input bit exp, input string name);
		if (got !== exp)
		begin
			$display("[FAIL] %0t ns %s got=%b exp=%b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic pick(input int n, output int v);
		v = {$random(seed)} % n;
	endtask

	task automatic emit(input logic [7:0] b);
		imem[gp] = b;
		gp = gp + 16'd1;
	endtask

	task automatic emit_imm_op();
		int k;

		pick(9, k);
		case (k)
			0: emit(f8_isa_pkg::LD_XL_IMMD);
			1: emit(f8_isa_pkg::ADD_XL_IMMD);
			2: emit(f8_isa_pkg::ADC_XL_IMMD);
			3: emit(f8_isa_pkg::SUB_XL_IMMD);
			4: emit(f8_isa_pkg::AND_XL_IMMD);
			5: emit(f8_isa_pkg::OR_XL_IMMD);
			6: emit(f8_isa_pkg::XOR_XL_IMMD);
			7: emit(f8_isa_pkg::INC_XL);
			default: emit(f8_isa_pkg::DEC_XL);
		endcase
		if (k < 7)
			emit($random(seed));
	endtask

	// one-byte ops keep skipped code aligned on both branch paths
	task automatic emit_short_op();
		int k;

		pick(6, k);
		case (k)
			0: emit(f8_isa_pkg::INC_XL);
			1: emit(f8_isa_pkg::DEC_XL);
			2: emit(f8_isa_pkg::ADD_XL_YL);
			3: emit(f8_isa_pkg::SUB_XL_ZL);
			4: emit(f8_isa_pkg::AND_XL_YL);
			default: emit(f8_isa_pkg::XOR_XL_ZL);
		endcase
	endtask

	task automatic emit_direct(input logic [7:0] op);
		emit(op);
		emit($random(seed));
		emit(8'h80);
	endtask

	task automatic emit_branch();
		int k;
		int d;
		logic [15:0] target;

		emit(f8_isa_pkg::ADD_XL_IMMD);
		emit($random(seed));
		pick(5, k);
		pick(5, d);
		if (k == 4)
		begin
			target = gp + 16'd3 + 16'(d);
			emit(f8_isa_pkg::JP_IMMD);
			emit(target[7:0]);
			emit(target[15:8]);
		end
		else
		begin
			emit(f8_isa_pkg::JR_D + 8'(k));
			emit(8'(d));
		end
		repeat (d)
			emit_short_op();
		emit_direct(f8_isa_pkg::LD_DIR_XL);
	endtask

	task automatic gen_program(input int kind);
		int r;

		gp = `F8_RESET_PC;
		emit(f8_isa_pkg::LD_XL_IMMD);
		emit($random(seed));
		emit(f8_isa_pkg::LDW_Y_IMMD);
		emit($random(seed));
		emit($random(seed));
		emit(f8_isa_pkg::LDW_Z_IMMD);
		emit($random(seed));
		emit($random(seed));
		repeat (30)
		begin
			pick(10, r);
			if (r < 3)
				emit_direct(f8_isa_pkg::LD_DIR_XL);
			else if (kind == 1 && r == 3)
				emit_direct(f8_isa_pkg::LDW_DIR_Y);
			else if (kind == 1 && r < 6)
				emit_short_op();
			else if (kind == 2 && r < 6)
				emit_direct(f8_isa_pkg::LD_XL_DIR);
			else if (kind == 3 && r < 6)
				emit_branch();
			else
				emit_imm_op();
		end
		repeat (33)
			emit(f8_isa_pkg::TRAP);
		for (int a = 0; a < 65536; a++)
			dmem_init[a] = $random(seed);
	endtask

	task automatic run_program(input bit stall, input string name);
		int err_start;
		int cycles;
		int n;

		err_start = errors;
		@(posedge clk);
		reset <= 1'b1;
		stall_mode <= stall;
		for (int i = 0; i < 8; i++)
		begin
			@(negedge clk);
			// the core takes reset at the edge after it is driven
			if (i != 0)
			begin
				check_trap(trap, 1'b0, "trap");
				check_trap(|dwrite.en, 1'b0, "dwrite.en");
				check_trap(dread.en, 1'b0, "dread.en");
			end
		end
		dmem = dmem_init;
		obs_q.delete();
		trap_seen = 1'b0;
		late_writes = 0;
		@(posedge clk);
		reset <= 1'b0;

		cycles = 0;
		while (!trap_seen && cycles < 2000)
		begin
			@(posedge clk);
			cycles++;
		end
		if (!trap_seen)
			$display("%s: timeout, trap did not rise within 2000 cycles", name);
		check_trap(trap_seen, exp_trap, "trap");
		if (trap_seen)
		begin
			// let any write after the trap show up
			repeat (10)
				@(posedge clk);
			if (late_writes != 0)
			begin
				$display("%s: %0d writes appeared after trap", name, late_writes);
				errors++;
			end
			if (obs_q.size() != exp_q.size())
			begin
				$display("%s: %0d writes seen but %0d expected", name, obs_q.size(),
					exp_q.size());
				errors++;
			end
			n = (obs_q.size() < exp_q.size()) ? obs_q.size() : exp_q.size();
			for (int i = 0; i < n; i++)
				check_write(obs_q[i], exp_q[i], i);
		end

		if (errors == err_start)
		begin
			tests_passed++;
			$display("%s passed, %0d writes", name, obs_q.size());
		end
		else
		begin
			tests_failed++;
			$display("%s failed", name);
		end
	endtask

	initial
	begin
		string names [4];

		names[0] = "immediate alu";
		names[1] = "register operands";
		names[2] = "direct loads";
		names[3] = "control flow";
		clk = 1'b0;
		reset = 1'b1;
		iread_data = '0;
		iread_valid = 1'b0;
		dread_data = '0;
		stall_mode = 1'b0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int a = 0; a < 65536; a++)
			imem[a] = a[7:0] ^ a[15:8];

		for (int kind = 0; kind < 4; kind++)
		begin
			gen_program(kind);
			run_model(exp_trap);
			run_program(1'b0, names[kind]);
			run_program(1'b1, {names[kind], " with stalls"});
		end

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- Bender.yml
package:
  name: f8_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/f8_isa_pkg.sv
      - common/f8_bus_pkg.sv
      - core/f8_decoder.sv
      - core/f8_alu.sv
      - core/f8_regfile.sv
      - core/f8_fetch.sv
      - rtl/f8_core.sv
  - target: test
    include_dirs:
      - common
      - verification
    files:
      - verification/f8_tb.sv

//--- tb.f
+incdir+common
+incdir+verification
common/f8_isa_pkg.sv
common/f8_bus_pkg.sv
core/f8_decoder.sv
core/f8_alu.sv
core/f8_regfile.sv
core/f8_fetch.sv
rtl/f8_core.sv
verification/f8_tb.sv
